// File: hw/cad_pkg.sv
package cad_pkg;

  // Data widths
  localparam int DATA_W   = 8;
  localparam int RESULT_W = 20;

  // Kernel geometry; one image bank per kernel column
  localparam int KSIZE     = 5;
  localparam int NUM_BANKS = KSIZE;

  // ------------------------------
  // Scalar and row types
  // ------------------------------
  typedef logic signed [DATA_W-1:0] pixel_t;

  typedef logic signed [RESULT_W-1:0] result_t;

  // Five horizontally adjacent taps, index 0 is the leftmost column
  typedef pixel_t [KSIZE-1:0] tap_row_t;

endpackage

// File: hw/cad_ifs.sv
`timescale 1ns/1ps

// Write port into one of the two stores, valid whenever en is high
interface mem_wr_if #(
  parameter int SLOT_W = 4,
  parameter int POS_W  = 3
);
  import cad_pkg::*;

  logic              en;
  logic [SLOT_W-1:0] slot;
  logic [POS_W-1:0]  row;
  logic [POS_W-1:0]  col;
  pixel_t            data;

  modport ctrl (output en, slot, row, col, data);
  modport mem  (input en, slot, row, col, data);
endinterface

// Row read request, data returns one cycle later on the memory's taps port
interface tap_rd_if #(
  parameter int SLOT_W = 4,
  parameter int POS_W  = 3
);
  logic              en;
  logic [SLOT_W-1:0] slot;
  logic [POS_W-1:0]  row;
  logic [POS_W-1:0]  col;

  modport ctrl (output en, slot, row, col);
  modport mem  (input en, slot, row, col);
endinterface

// File: hw/cad_ctrl.sv
`timescale 1ns/1ps

module cad_ctrl #(
  parameter int IMG_SIZE  = 8,
  parameter int NUM_IMG   = 2,
  parameter int NUM_KER   = 2,
  parameter int NUM_QUERY = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  cad_pkg::pixel_t matrix,
  input  logic            in_valid2,
  input  logic [3:0]      matrix_idx,
  input  logic            slot_free,
  mem_wr_if.ctrl          img_wr,
  mem_wr_if.ctrl          ker_wr,
  tap_rd_if.ctrl          img_rd,
  tap_rd_if.ctrl          ker_rd,
  output logic            acc_first
);
  import cad_pkg::*;

  localparam int POS_W   = $clog2(IMG_SIZE);
  localparam int QRY_W   = $clog2(NUM_QUERY + 1);
  localparam int WIN_END = IMG_SIZE - KSIZE;

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_LOAD     = 2'd1;
  localparam logic [1:0] ST_WAIT_IDX = 2'd2;
  localparam logic [1:0] ST_PROC     = 2'd3;

  logic [1:0]       state;
  logic [1:0]       state_nxt;
  logic             loading;
  logic             load_done;
  logic             ld_ker;
  logic [3:0]       ld_slot;
  logic [3:0]       slot_lim;
  logic [POS_W-1:0] ld_row;
  logic [POS_W-1:0] ld_col;
  logic [POS_W-1:0] ld_lim;
  logic             idx_half;
  logic [3:0]       img_idx;
  logic [3:0]       ker_idx;
  logic [QRY_W-1:0] qry_cnt;
  logic [POS_W-1:0] win_x;
  logic [POS_W-1:0] win_y;
  logic [POS_W-1:0] krow;
  logic             rd_go;
  logic             scan_done;

  // ------------------------------
  // Phase FSM
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:     if (in_valid) state_nxt = ST_LOAD;
      ST_LOAD:     if (load_done) state_nxt = ST_WAIT_IDX;
      ST_WAIT_IDX: if (in_valid2 && idx_half) state_nxt = ST_PROC;
      default:
      begin
        if (scan_done)
          state_nxt = (qry_cnt == QRY_W'(NUM_QUERY - 1)) ? ST_IDLE : ST_WAIT_IDX;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // ------------------------------
  // Load pointers
  // ------------------------------
  // First pixel is sampled while still idle, so pointers rest at zero there
  assign loading   = in_valid && (state == ST_IDLE || state == ST_LOAD);
  assign ld_lim    = ld_ker ? POS_W'(KSIZE - 1) : POS_W'(IMG_SIZE - 1);
  assign slot_lim  = ld_ker ? 4'(NUM_KER - 1) : 4'(NUM_IMG - 1);
  assign load_done = loading && ld_ker && ld_col == ld_lim && ld_row == ld_lim
                     && ld_slot == slot_lim;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ld_ker  <= 1'b0;
      ld_slot <= '0;
      ld_row  <= '0;
      ld_col  <= '0;
    end
    else if (loading)
    begin
      if (ld_col != ld_lim)
        ld_col <= ld_col + 1'b1;
      else
      begin
        ld_col <= '0;
        if (ld_row != ld_lim)
          ld_row <= ld_row + 1'b1;
        else
        begin
          ld_row <= '0;
          if (ld_slot != slot_lim)
            ld_slot <= ld_slot + 1'b1;
          else
          begin
            // Images done -> kernels, kernels done -> back to images
            ld_slot <= '0;
            ld_ker  <= !ld_ker;
          end
        end
      end
    end
  end

  assign img_wr.en   = loading && !ld_ker;
  assign img_wr.slot = ld_slot;
  assign img_wr.row  = ld_row;
  assign img_wr.col  = ld_col;
  assign img_wr.data = matrix;

  assign ker_wr.en   = loading && ld_ker;
  assign ker_wr.slot = ld_slot;
  assign ker_wr.row  = ld_row;
  assign ker_wr.col  = ld_col;
  assign ker_wr.data = matrix;

  // ------------------------------
  // Index latch and query count
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      idx_half <= 1'b0;
      img_idx  <= '0;
      ker_idx  <= '0;
      qry_cnt  <= '0;
    end
    else
    begin
      if (state == ST_WAIT_IDX && in_valid2)
      begin
        if (!idx_half)
          img_idx <= matrix_idx;
        else
          ker_idx <= matrix_idx;
        idx_half <= !idx_half;
      end
      if (scan_done)
        qry_cnt <= (qry_cnt == QRY_W'(NUM_QUERY - 1)) ? '0 : qry_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Window scan
  // ------------------------------
  // Stall only at kernel row 0, a started window always runs its five reads
  assign rd_go     = (state == ST_PROC) && (krow != '0 || slot_free);
  assign scan_done = rd_go && krow == POS_W'(KSIZE - 1)
                     && win_x == POS_W'(WIN_END) && win_y == POS_W'(WIN_END);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      krow  <= '0;
      win_x <= '0;
      win_y <= '0;
    end
    else if (rd_go)
    begin
      if (krow != POS_W'(KSIZE - 1))
        krow <= krow + 1'b1;
      else
      begin
        krow <= '0;
        if (win_x != POS_W'(WIN_END))
          win_x <= win_x + 1'b1;
        else
        begin
          win_x <= '0;
          win_y <= (win_y != POS_W'(WIN_END)) ? win_y + 1'b1 : '0;
        end
      end
    end
  end

  assign img_rd.en   = rd_go;
  assign img_rd.slot = img_idx;
  assign img_rd.row  = win_y + krow;
  assign img_rd.col  = win_x;

  assign ker_rd.en   = rd_go;
  assign ker_rd.slot = ker_idx;
  assign ker_rd.row  = krow;
  assign ker_rd.col  = '0;

  assign acc_first = rd_go && krow == '0;

endmodule

// File: hw/img_bank_mem.sv
`timescale 1ns/1ps

module img_bank_mem #(
  parameter int IMG_SIZE = 8,
  parameter int NUM_IMG  = 2
) (
  input  logic              clk,
  mem_wr_if.mem             wr,
  tap_rd_if.mem             rd,
  output cad_pkg::tap_row_t taps
);
  import cad_pkg::*;

  // Column c lives in bank c mod 5, block c div 5 of its row
  localparam int BLOCKS = (IMG_SIZE + NUM_BANKS - 1) / NUM_BANKS;
  localparam int DEPTH  = NUM_IMG * IMG_SIZE * BLOCKS;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int BANK_W = $clog2(NUM_BANKS);

  pixel_t            mem [NUM_BANKS][DEPTH];
  pixel_t            bank_q [NUM_BANKS];
  logic [BANK_W-1:0] wr_bank;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr [NUM_BANKS];
  logic [BANK_W-1:0] rot_q;
  int                rd_base;
  int                tap_col;

  always_comb
  begin
    wr_bank = BANK_W'(int'(wr.col) % NUM_BANKS);
    wr_addr = ADDR_W'((int'(wr.slot) * IMG_SIZE + int'(wr.row)) * BLOCKS
                      + int'(wr.col) / NUM_BANKS);
  end

  // Each bank serves the one window column that maps onto it
  always_comb
  begin
    rd_base = (int'(rd.slot) * IMG_SIZE + int'(rd.row)) * BLOCKS;
    tap_col = 0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      tap_col    = int'(rd.col) + (b - int'(rd.col) % NUM_BANKS + NUM_BANKS) % NUM_BANKS;
      rd_addr[b] = ADDR_W'(rd_base + tap_col / NUM_BANKS);
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr.en)
      mem[wr_bank][wr_addr] <= wr.data;
    if (rd.en)
    begin
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        bank_q[b] <= mem[b][rd_addr[b]];
      end
      rot_q <= BANK_W'(int'(rd.col) % NUM_BANKS);
    end
  end

  // Rotate bank order back into column order
  always_comb
  begin
    for (int k = 0; k < KSIZE; k++)
    begin
      taps[k] = bank_q[(int'(rot_q) + k) % NUM_BANKS];
    end
  end

endmodule

// File: hw/kernel_mem.sv
`timescale 1ns/1ps

module kernel_mem #(
  parameter int NUM_KER = 2
) (
  input  logic              clk,
  mem_wr_if.mem             wr,
  tap_rd_if.mem             rd,
  output cad_pkg::tap_row_t taps
);
  import cad_pkg::*;

  // One bank per kernel column, one word per kernel row
  localparam int DEPTH  = NUM_KER * KSIZE;
  localparam int ADDR_W = $clog2(DEPTH);

  pixel_t            mem [KSIZE][DEPTH];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;

  assign wr_addr = ADDR_W'(int'(wr.slot) * KSIZE + int'(wr.row));
  assign rd_addr = ADDR_W'(int'(rd.slot) * KSIZE + int'(rd.row));

  always_ff @(posedge clk)
  begin
    if (wr.en)
      mem[wr.col][wr_addr] <= wr.data;
    // All five weights of a row come back together
    if (rd.en)
    begin
      for (int k = 0; k < KSIZE; k++)
      begin
        taps[k] <= mem[k][rd_addr];
      end
    end
  end

endmodule

// File: hw/conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
  input  logic              clk,
  input  logic              rst_n,
  input  cad_pkg::tap_row_t img_taps,
  input  cad_pkg::tap_row_t ker_taps,
  input  logic              acc_first,
  output cad_pkg::result_t  res,
  output logic              res_valid
);
  import cad_pkg::*;

  logic       first_d;
  logic [2:0] row_cnt;
  result_t    row_sum;
  result_t    acc;

  // Five signed products summed at full result width
  always_comb
  begin
    row_sum = '0;
    for (int k = 0; k < KSIZE; k++)
    begin
      row_sum = row_sum + result_t'(img_taps[k]) * result_t'(ker_taps[k]);
    end
  end

  // ------------------------------
  // Row counting
  // ------------------------------
  // acc_first is issued with the read and data shows up one cycle later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      first_d   <= 1'b0;
      row_cnt   <= '0;
      res_valid <= 1'b0;
    end
    else
    begin
      first_d   <= acc_first;
      res_valid <= (row_cnt == 3'(KSIZE - 1));
      if (first_d)
        row_cnt <= 3'd1;
      else if (row_cnt == 3'(KSIZE - 1))
        row_cnt <= '0;
      else if (row_cnt != '0)
        row_cnt <= row_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (first_d)
      acc <= row_sum;
    else if (row_cnt != '0)
      acc <= acc + row_sum;
  end

  assign res = acc;

endmodule

// File: hw/serial_out.sv
`timescale 1ns/1ps

module serial_out (
  input  logic             clk,
  input  logic             rst_n,
  input  cad_pkg::result_t res,
  input  logic             res_valid,
  output logic             slot_free,
  output logic             out_valid,
  output logic             out_value
);
  import cad_pkg::*;

  localparam int CNT_W = $clog2(RESULT_W);

  result_t             buf_q;
  logic                buf_full;
  logic [RESULT_W-1:0] sh_q;
  logic [CNT_W-1:0]    bit_cnt;
  logic                busy;
  logic                last_bit;
  logic                load;

  assign last_bit = busy && bit_cnt == CNT_W'(RESULT_W - 1);
  // Buffer moves on when the shifter is idle or finishing, so results run back to back
  assign load     = buf_full && (!busy || last_bit);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      buf_full <= 1'b0;
      busy     <= 1'b0;
      bit_cnt  <= '0;
    end
    else
    begin
      buf_full <= res_valid || (buf_full && !load);
      if (load)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
      else if (last_bit)
        busy <= 1'b0;
      else if (busy)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (res_valid)
      buf_q <= res;
    if (load)
      sh_q <= buf_q;
    else if (busy)
      sh_q <= sh_q >> 1;
  end

  // No new window while anything is held, the one in flight still needs a place
  assign slot_free = !buf_full && !busy;
  assign out_valid = busy;
  assign out_value = busy && sh_q[0];

endmodule

// File: hw/cad.sv
`timescale 1ns/1ps

module cad #(
  parameter int IMG_SIZE  = 8,
  parameter int NUM_IMG   = 2,
  parameter int NUM_KER   = 2,
  parameter int NUM_QUERY = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  cad_pkg::pixel_t matrix,
  input  logic            in_valid2,
  input  logic [3:0]      matrix_idx,
  output logic            out_valid,
  output logic            out_value
);
  import cad_pkg::*;

  localparam int POS_W = $clog2(IMG_SIZE);

  tap_row_t img_taps;
  tap_row_t ker_taps;
  result_t  res;
  logic     res_valid;
  logic     slot_free;
  logic     acc_first;

  mem_wr_if #(.POS_W(POS_W)) img_wr ();
  mem_wr_if #(.POS_W(POS_W)) ker_wr ();
  tap_rd_if #(.POS_W(POS_W)) img_rd ();
  tap_rd_if #(.POS_W(POS_W)) ker_rd ();

  // ------------------------------
  // Control and storage
  // ------------------------------
  cad_ctrl #(
    .IMG_SIZE  (IMG_SIZE),
    .NUM_IMG   (NUM_IMG),
    .NUM_KER   (NUM_KER),
    .NUM_QUERY (NUM_QUERY)
  ) i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .matrix     (matrix),
    .in_valid2  (in_valid2),
    .matrix_idx (matrix_idx),
    .slot_free  (slot_free),
    .img_wr     (img_wr.ctrl),
    .ker_wr     (ker_wr.ctrl),
    .img_rd     (img_rd.ctrl),
    .ker_rd     (ker_rd.ctrl),
    .acc_first  (acc_first)
  );

  img_bank_mem #(
    .IMG_SIZE (IMG_SIZE),
    .NUM_IMG  (NUM_IMG)
  ) i_img_mem (
    .clk  (clk),
    .wr   (img_wr.mem),
    .rd   (img_rd.mem),
    .taps (img_taps)
  );

  kernel_mem #(
    .NUM_KER (NUM_KER)
  ) i_ker_mem (
    .clk  (clk),
    .wr   (ker_wr.mem),
    .rd   (ker_rd.mem),
    .taps (ker_taps)
  );

  // ------------------------------
  // Datapath and output
  // ------------------------------
  conv_mac i_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .img_taps  (img_taps),
    .ker_taps  (ker_taps),
    .acc_first (acc_first),
    .res       (res),
    .res_valid (res_valid)
  );

  serial_out i_ser (
    .clk       (clk),
    .rst_n     (rst_n),
    .res       (res),
    .res_valid (res_valid),
    .slot_free (slot_free),
    .out_valid (out_valid),
    .out_value (out_value)
  );

endmodule

// File: tests/cad_chk.sv
`timescale 1ns/1ps

module cad_chk (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic in_valid2,
  input logic out_valid,
  input logic out_value
);

  // Serial line stays low between results
  quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid |-> !out_value)
    else $error("out_value high while out_valid is low");

  // Load and index phases never overlap
  phases_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_valid && in_valid2))
    else $error("in_valid and in_valid2 high in the same cycle");

  idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind cad cad_chk i_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_valid2 (in_valid2),
  .out_valid (out_valid),
  .out_value (out_value)
);

// File: tests/cad_tb.sv
`timescale 1ns/1ps

module cad_tb;
  import cad_pkg::*;

  // Mirrors the DUT defaults
  localparam int IMG_SIZE       = 8;
  localparam int NUM_IMG        = 2;
  localparam int NUM_KER        = 2;
  localparam int CLK_PERIOD     = 4;
  localparam int LOAD_LEN       = NUM_IMG * IMG_SIZE * IMG_SIZE + NUM_KER * KSIZE * KSIZE;
  localparam int WINDOWS        = (IMG_SIZE - KSIZE + 1) * (IMG_SIZE - KSIZE + 1);
  localparam int QRY_REC        = 2 + WINDOWS;
  localparam int NUM_RUNS       = 3;
  localparam int GOLD_WORDS     = LOAD_LEN + NUM_RUNS * QRY_REC;
  localparam int DRAIN_CYCLES   = 40;
  localparam int TIMEOUT_CYCLES = 2 * LOAD_LEN + NUM_RUNS * WINDOWS * RESULT_W * 50 + 200;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       in_valid;
  pixel_t     matrix;
  logic       in_valid2;
  logic [3:0] matrix_idx;
  logic       out_valid;
  logic       out_value;

  logic [31:0]         gold [0:GOLD_WORDS-1];
  logic [RESULT_W-1:0] expected [$];
  logic [RESULT_W-1:0] shift_q;
  logic [RESULT_W-1:0] exp_val;
  int                  bit_idx;

  cad i_cad (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .matrix     (matrix),
    .in_valid2  (in_valid2),
    .matrix_idx (matrix_idx),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Images then kernels at one value per cycle
  task automatic load_data();
    for (int i = 0; i < LOAD_LEN; i++)
    begin
      @(posedge clk);
      in_valid <= 1'b1;
      matrix   <= pixel_t'(gold[i][7:0]);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    matrix   <= '0;
    repeat (3) @(posedge clk);
  endtask

  task automatic run_query(input int q);
    int base;
    base = LOAD_LEN + q * QRY_REC;
    for (int k = 0; k < WINDOWS; k++)
    begin
      expected.push_back(gold[base + 2 + k][RESULT_W-1:0]);
    end
    @(posedge clk);
    in_valid2  <= 1'b1;
    matrix_idx <= gold[base][3:0];
    @(posedge clk);
    matrix_idx <= gold[base + 1][3:0];
    @(posedge clk);
    in_valid2  <= 1'b0;
    matrix_idx <= '0;
    while (expected.size() != 0 || bit_idx != 0)
      @(posedge clk);
    // Quiet period where any stray bit trips the collector
    repeat (DRAIN_CYCLES) @(posedge clk);
  endtask

  // ------------------------------
  // Output collection
  // ------------------------------
  // Sampled mid-cycle with the LSB first
  always @(negedge clk)
  begin
    if (out_valid)
    begin
      assert (expected.size() != 0)
      else
        abort_run("out_valid went high with no result pending");
      shift_q = {out_value, shift_q[RESULT_W-1:1]};
      bit_idx++;
      if (bit_idx == RESULT_W)
      begin
        exp_val = expected.pop_front();
        assert (shift_q == exp_val)
        else
          abort_run($sformatf("Mismatch out_value: expected %05h, got %05h",
                              exp_val, shift_q));
        bit_idx = 0;
      end
    end
    else
    begin
      assert (bit_idx == 0)
      else
        abort_run($sformatf("out_valid dropped after %0d bits of a result", bit_idx));
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abort_run("Timeout: the DUT did not deliver all results in time");
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    matrix       = '0;
    in_valid2    = 1'b0;
    matrix_idx   = '0;
    shift_q      = '0;
    bit_idx      = 0;
    $readmemh("tests/cad_golden.hex", gold);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Nothing comes out before any input
    repeat (10)
    begin
      @(negedge clk);
      assert (!out_valid)
      else
        abort_run("out_valid high before any input");
    end

    load_data();
    run_query(0);
    run_query(1);
    // Controller is back in idle and takes a fresh load
    load_data();
    run_query(2);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: tests/cad_golden.hex
// Images: 2 images, 8 rows of 8 signed pixels each, row-major
// Kernels: 2 kernels, 5 rows of 5 signed weights each
// Queries: image index, kernel index, then 16 expected 20-bit results, windows row-major
// Image 0
00 01 02 03 04 05 06 07
08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17
18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27
28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37
38 39 3a 3b 3c 3d 3e 3f
// Image 1
f6 f9 fc ff 02 05 08 0b
f4 f7 fa fd 00 03 06 09
f2 f5 f8 fb fe 01 04 07
f0 f3 f6 f9 fc ff 02 05
ee f1 f4 f7 fa fd 00 03
ec ef f2 f5 f8 fb fe 01
ea ed f0 f3 f6 f9 fc ff
e8 eb ee f1 f4 f7 fa fd
// Kernel 0
01 02 03 04 05
00 01 02 03 04
ff 00 01 02 03
fe ff 00 01 02
fd fe ff 00 01
// Kernel 1
00 ff fe fd fc
02 01 00 ff fe
04 03 02 01 00
06 05 04 03 02
08 07 06 05 04
// Query 1: image 0, kernel 0
0 0
00064 0007d 00096 000af 0012c 00145 0015e 00177
001f4 0020d 00226 0023f 002bc 002d5 002ee 00307
// Query 2: image 1, kernel 1
1 1
ffd12 ffda8 ffe3e ffed4 ffcae ffd44 ffdda ffe70
ffc4a ffce0 ffd76 ffe0c ffbe6 ffc7c ffd12 ffda8
// Query 3, after the second load: image 1, kernel 0
1 0
00032 0007d 000c8 00113 00000 0004b 00096 000e1
fffce 00019 00064 000af fff9c fffe7 00032 0007d

// File: src.f
hw/cad_pkg.sv
hw/cad_ifs.sv
hw/cad_ctrl.sv
hw/img_bank_mem.sv
hw/kernel_mem.sv
hw/conv_mac.sv
hw/serial_out.sv
hw/cad.sv
tests/cad_chk.sv
tests/cad_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cad_tb -f src.f
./obj_dir/Vcad_tb
